/* alu.sv */
`default_nettype none
`timescale 1ns/1ns

module alu import lc3b_pkg::*; (
	input alu_ops aluop,
	input lc3b_word a,
	input lc3b_word b,
	output lc3b_word f
);

logic [3:0] amount;

assign amount = b[3:0];	// shifts use the low four bits only

always_comb begin
	case (aluop)
	alu_add: begin
		f = a + b;
	end
	alu_and: begin
		f = a & b;
	end
	alu_not: begin
		f = ~a;
	end
	alu_sll: begin
		f = a << amount;
	end
	alu_srl: begin
		f = a >> amount;
	end
	alu_sra: begin
		f = lc3b_word'($signed(a) >>> amount);
	end
	alu_pass: begin
		f = a;
	end
	default: begin
		f = a;
	end
	endcase
end

endmodule

`default_nettype wire

/* compile.f */
lc3b_pkg.sv
pipe_reg.sv
regfile.sv
instr_decode.sv
alu.sv
execute.sv
lc3b_core.sv
tb_clock.sv
tb_lc3b_core.sv

/* execute.sv */
`default_nettype none
`timescale 1ns/1ns

module execute import lc3b_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic stall,
	input id_ex_t id_ex,
	output retire_t retire,
	output logic [2:0] cc
);

lc3b_word imm5;
lc3b_word shamt;
lc3b_word off9;
lc3b_word alu_a;
lc3b_word alu_b;
lc3b_word alu_f;
logic [2:0] nzp;
logic fire;

assign imm5 = {{11{id_ex.intr[4]}}, id_ex.intr[4:0]};
assign shamt = {12'd0, id_ex.intr[3:0]};
assign off9 = {{6{id_ex.intr[8]}}, id_ex.intr[8:0], 1'b0};	// word offset

assign alu_a = id_ex.ctrl.srca_pc ? id_ex.pc : id_ex.srca;

always_comb begin
	case (id_ex.ctrl.srcb_sel)
	srcb_imm5: alu_b = imm5;
	srcb_shamt: alu_b = shamt;
	srcb_off9: alu_b = off9;
	default: alu_b = id_ex.srcb;
	endcase
end

alu alu_inst (
	.aluop(id_ex.ctrl.aluop),
	.a(alu_a),
	.b(alu_b),
	.f(alu_f)
);

assign nzp = {alu_f[15], alu_f == 16'd0, !alu_f[15] && alu_f != 16'd0};
assign fire = id_ex.valid && !stall;	// held instruction retires once stall drops

assign retire.valid = fire;
assign retire.write = fire && id_ex.ctrl.load_regfile;
assign retire.dest = id_ex.destreg;
assign retire.value = alu_f;
assign retire.cc = (fire && id_ex.ctrl.load_cc) ? nzp : cc;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		cc <= 3'b010;
	end else if (fire && id_ex.ctrl.load_cc) begin
		cc <= nzp;
	end
end

assert property (@(posedge clk) disable iff (!arst_n) $onehot(cc))
	else $error("execute: condition codes not one-hot");

endmodule

`default_nettype wire

/* instr_decode.sv */
`default_nettype none
`timescale 1ns/1ns

module instr_decode import lc3b_pkg::*; (
	input if_id_t if_id,
	output ctrl_t ctrl,
	output lc3b_reg destreg,
	output lc3b_reg sr1,
	output lc3b_reg sr2
);

lc3b_opcode opcode;
logic reg_form;

assign opcode = lc3b_opcode'(if_id.intr[15:12]);
assign reg_form = (opcode == op_add) || (opcode == op_and);

assign destreg = if_id.intr[11:9];
assign sr1 = if_id.intr[8:6];
assign sr2 = reg_form ? if_id.intr[2:0] : if_id.intr[11:9];	// stores read sr from [11:9]

always_comb begin
	ctrl = '0;
	if (if_id.valid) begin
		case (opcode)
		op_add: begin
			ctrl.aluop = alu_add;
			if (if_id.intr[5]) begin
				ctrl.srcb_sel = srcb_imm5;
			end else begin
				ctrl.srcb_sel = srcb_reg;
			end
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end
		op_and: begin
			ctrl.aluop = alu_and;
			if (if_id.intr[5]) begin
				ctrl.srcb_sel = srcb_imm5;
			end else begin
				ctrl.srcb_sel = srcb_reg;
			end
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end
		op_not: begin
			ctrl.aluop = alu_not;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end
		op_shf: begin
			ctrl.srcb_sel = srcb_shamt;
			if (!if_id.intr[4]) begin
				ctrl.aluop = alu_sll;
			end else if (!if_id.intr[5]) begin
				ctrl.aluop = alu_srl;
			end else begin
				ctrl.aluop = alu_sra;
			end
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end
		op_lea: begin
			ctrl.srcb_sel = srcb_off9;	// pc + sext(off9) << 1
			ctrl.srca_pc = 1'b1;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end
		default: begin
			// memory, branch, jump and trap retire with no effect
			ctrl = '0;
		end
		endcase
	end
	// cc only ever follows a register result
	assert (!ctrl.load_cc || ctrl.load_regfile)
		else $error("instr_decode: load_cc without load_regfile");
end

endmodule

`default_nettype wire

/* lc3b_core.sv */
`default_nettype none
`timescale 1ns/1ns

module lc3b_core import lc3b_pkg::*; (
	input logic clk,
	input logic arst_n,
	input lc3b_word instr,
	input lc3b_word pc,
	input logic instr_valid,
	input logic stall,
	output retire_t retire,
	output logic [2:0] cc
);

if_id_t if_id_d;
if_id_t if_id;
id_ex_t id_ex_d;
id_ex_t id_ex;
ctrl_t ctrl;
lc3b_reg destreg;
lc3b_reg sr1;
lc3b_reg sr2;
lc3b_word srca;
lc3b_word srcb;

assign if_id_d = '{valid: instr_valid, pc: pc, intr: instr};

pipe_reg #(.T(if_id_t)) if_id_reg (
	.clk,
	.arst_n,
	.stall,
	.d(if_id_d),
	.q(if_id)
);

instr_decode decoder (
	.if_id,
	.ctrl,
	.destreg,
	.sr1,
	.sr2
);

regfile rf (
	.clk,
	.arst_n,
	.sr1,
	.sr2,
	.wr(retire),	// write back from execute
	.srca,
	.srcb
);

assign id_ex_d = '{valid: if_id.valid, ctrl: ctrl, destreg: destreg, srca: srca,
	srcb: srcb, intr: if_id.intr, pc: if_id.pc};

pipe_reg #(.T(id_ex_t)) id_ex_reg (
	.clk,
	.arst_n,
	.stall,
	.d(id_ex_d),
	.q(id_ex)
);

execute ex_stage (
	.clk,
	.arst_n,
	.stall,
	.id_ex,
	.retire,
	.cc
);

endmodule

`default_nettype wire

/* lc3b_pkg.sv */
`default_nettype none

package lc3b_pkg;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;

typedef enum logic [3:0] {
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_jsr  = 4'b0100,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_rti  = 4'b1000,
	op_not  = 4'b1001,
	op_ldi  = 4'b1010,
	op_sti  = 4'b1011,
	op_jmp  = 4'b1100,
	op_shf  = 4'b1101,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [2:0] {
	alu_add,	// zero value, so a cleared ctrl selects add
	alu_and,
	alu_not,
	alu_pass,
	alu_sll,
	alu_srl,
	alu_sra
} alu_ops;

typedef enum logic [1:0] {
	srcb_reg,
	srcb_imm5,
	srcb_shamt,
	srcb_off9
} srcb_sel_t;

typedef struct packed {
	alu_ops aluop;
	srcb_sel_t srcb_sel;
	logic srca_pc;	// operand a from the pc
	logic load_regfile;
	logic load_cc;
} ctrl_t;

typedef struct packed {
	logic valid;
	lc3b_word pc;	// already incremented
	lc3b_word intr;
} if_id_t;

typedef struct packed {
	logic valid;
	ctrl_t ctrl;
	lc3b_reg destreg;
	lc3b_word srca;
	lc3b_word srcb;
	lc3b_word intr;
	lc3b_word pc;
} id_ex_t;

typedef struct packed {
	logic valid;
	logic write;
	lc3b_reg dest;
	lc3b_word value;
	logic [2:0] cc;	// n, z, p
} retire_t;

endpackage

`default_nettype wire

/* pipe_reg.sv */
`default_nettype none
`timescale 1ns/1ns

module pipe_reg #(
	parameter type T = logic
) (
	input logic clk,
	input logic arst_n,
	input logic stall,
	input T d,
	output T q
);

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		q <= '0;	// all zero is a bubble
	end else if (!stall) begin
		q <= d;
	end
end

// the upstream stage must present settled data whenever it is taken
assert property (@(posedge clk) disable iff (!arst_n) !stall |-> !$isunknown(d))
	else $error("pipe_reg: unknown bits loaded into stage register");

endmodule

`default_nettype wire

/* regfile.sv */
`default_nettype none
`timescale 1ns/1ns

module regfile import lc3b_pkg::*; (
	input logic clk,
	input logic arst_n,
	input lc3b_reg sr1,
	input lc3b_reg sr2,
	input retire_t wr,
	output lc3b_word srca,
	output lc3b_word srcb
);

lc3b_word regs [8];

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		for (int i = 0; i < 8; i++) begin
			regs[i] <= '0;
		end
	end else if (wr.write) begin
		regs[wr.dest] <= wr.value;
	end
end

// a result retiring now is seen by the instruction in decode
always_comb begin
	if (wr.write && wr.dest == sr1) begin
		srca = wr.value;
	end else begin
		srca = regs[sr1];
	end
	if (wr.write && wr.dest == sr2) begin
		srcb = wr.value;
	end else begin
		srcb = regs[sr2];
	end
end

// execute must never request a write for an instruction that did not retire
assert property (@(posedge clk) disable iff (!arst_n) wr.write |-> wr.valid)
	else $error("regfile: write without a retiring instruction");

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the LC-3b decode/execute testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f compile.f \
	--top-module tb_lc3b_core \
	--Mdir obj_dir \
	-o sim_lc3b
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_lc3b > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "test passed" sim.log; then
	exit 0
else
	echo "pass message not found in sim.log"
	exit 1
fi

/* tb_clock.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic arst_n
);

initial begin
	clk = 1'b0;
	forever begin
		#5 clk = ~clk;	// 10 ns period
	end
end

initial begin
	arst_n = 1'b0;
	repeat (4) begin
		@(posedge clk);
	end
	#2 arst_n = 1'b1;	// released between edges
end

endmodule

`default_nettype wire

/* tb_lc3b_core.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_lc3b_core import lc3b_pkg::*; ();

localparam int NUM_INSTR = 47;
localparam int CYCLE_LIMIT = 4 * NUM_INSTR + 100;

typedef struct packed {
	logic write;
	lc3b_reg dest;
	lc3b_word value;
	logic [2:0] cc;
	logic [31:0] cycle;	// edge that sampled it
	logic [31:0] stalls;	// stalled cycles before that edge
} expect_t;

logic clk;
logic arst_n;
lc3b_word instr;
lc3b_word pc;
logic instr_valid;
logic stall;
retire_t retire;
logic [2:0] cc;

lc3b_word model_regs [8];
logic [2:0] model_cc;
logic [2:0] committed_cc;	// what the cc register holds now
expect_t pending [$];
int unsigned edge_cnt;
int unsigned stall_cnt;
int unsigned timeout_cnt = 0;
lc3b_word next_pc;

tb_clock clock_gen (
	.clk,
	.arst_n
);

lc3b_core UUT (
	.clk,
	.arst_n,
	.instr,
	.pc,
	.instr_valid,
	.stall,
	.retire,
	.cc
);

always @(posedge clk) begin
	timeout_cnt++;
	if (timeout_cnt >= CYCLE_LIMIT) begin
		$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("test failed");
		$fatal(1, "run stopped by the cycle limit");
	end
end

function automatic logic [2:0] nzp_of(input lc3b_word v);
	if (v[15]) begin
		return 3'b100;
	end else if (v == 16'h0000) begin
		return 3'b010;
	end
	return 3'b001;
endfunction

function automatic lc3b_word alu_instr(input logic [3:0] op, input lc3b_reg dr,
	input lc3b_reg sr1, input logic imm_form, input logic [4:0] low);
	if (imm_form) begin
		return {op, dr, sr1, 1'b1, low};
	end
	return {op, dr, sr1, 3'b000, low[2:0]};
endfunction

function automatic lc3b_word not_instr(input lc3b_reg dr, input lc3b_reg sr);
	return {4'h9, dr, sr, 6'h3f};
endfunction

// kind is {intr[5], intr[4]}
function automatic lc3b_word shift_instr(input lc3b_reg dr, input lc3b_reg sr,
	input logic [1:0] kind, input logic [3:0] amt);
	return {4'hd, dr, sr, kind, amt};
endfunction

function automatic lc3b_word lea_instr(input lc3b_reg dr, input logic [8:0] off);
	return {4'he, dr, off};
endfunction

function automatic lc3b_reg any_dest();
	return lc3b_reg'($urandom_range(7, 1));	// r0 stays zero
endfunction

task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
	assert (act === exp) else begin
		$display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
		$display("test failed");
		$fatal(1, "stopped at the first mismatch");
	end
endtask

task automatic abort_run(input string why);
	$display("%s", why);
	$display("test failed");
	$fatal(1, "stopped on a protocol error");
endtask

// reference model applied in program order when an instruction is taken
task automatic reference_step(input lc3b_word ins, input lc3b_word pcv);
	expect_t e;
	lc3b_word a;
	lc3b_word b;
	lc3b_word res;
	logic wr;
	a = model_regs[ins[8:6]];
	b = ins[5] ? {{11{ins[4]}}, ins[4:0]} : model_regs[ins[2:0]];
	res = '0;
	wr = 1'b1;
	case (ins[15:12])
	4'h1: res = a + b;
	4'h5: res = a & b;
	4'h9: res = ~a;
	4'hd: begin
		if (!ins[4]) begin
			res = a << ins[3:0];
		end else if (!ins[5]) begin
			res = a >> ins[3:0];
		end else begin
			res = $signed(a) >>> ins[3:0];
		end
	end
	4'he: res = pcv + {{6{ins[8]}}, ins[8:0], 1'b0};
	default: wr = 1'b0;	// memory, control flow and trap
	endcase
	if (wr) begin
		model_regs[ins[11:9]] = res;
		model_cc = nzp_of(res);
	end
	e.write = wr;
	e.dest = ins[11:9];
	e.value = res;
	e.cc = model_cc;
	e.cycle = edge_cnt;
	e.stalls = stall_cnt;
	pending.push_back(e);
endtask

task automatic check_retire;
	expect_t e;
	expect_eq("cc", 32'(committed_cc), 32'(cc));
	if (stall) begin
		expect_eq("retire.valid", 32'd0, 32'(retire.valid));
		stall_cnt++;
	end
	if (retire.valid) begin
		assert (pending.size() != 0) else abort_run("an instruction retired that was never sent");
		e = pending.pop_front();
		expect_eq("retire.write", 32'(e.write), 32'(retire.write));
		if (e.write) begin
			expect_eq("retire.dest", 32'(e.dest), 32'(retire.dest));
			expect_eq("retire.value", 32'(e.value), 32'(retire.value));
		end
		expect_eq("retire.cc", 32'(e.cc), 32'(retire.cc));
		expect_eq("retire.valid edge", e.cycle + 1 + (stall_cnt - e.stalls), edge_cnt);
		committed_cc = e.cc;
	end
endtask

// one clock cycle that drives, checks at the falling edge and then models what was taken
task automatic issue(input lc3b_word ins, input lc3b_word pcv, input logic v, input logic st);
	#1;
	instr = ins;
	pc = pcv;
	instr_valid = v;
	stall = st;
	@(negedge clk);
	check_retire();
	@(posedge clk);
	edge_cnt++;
	if (v && !st) begin
		reference_step(ins, pcv);
	end
endtask

task automatic send(input lc3b_word ins);
	issue(ins, next_pc, 1'b1, 1'b0);
	next_pc = next_pc + 16'd2;
endtask

task automatic idle(input int n);
	repeat (n) begin
		issue(16'h0000, next_pc, 1'b0, 1'b0);
	end
endtask

task automatic reset_state;
	idle(3);	// no retire and cc still z
	send(not_instr(3'd1, 3'd0));
	idle(2);
endtask

task automatic add_and_ops;
	lc3b_reg prev;
	lc3b_reg dr;
	logic [3:0] op;
	logic imm_form;
	logic [4:0] low;
	prev = 3'd1;
	for (int i = 0; i < 12; i++) begin
		dr = any_dest();
		op = $urandom_range(1) ? 4'h5 : 4'h1;
		imm_form = (i == 0) ? 1'b1 : 1'($urandom);
		low = (i == 0) ? {1'b1, 4'($urandom)} : 5'($urandom);	// first imm negative
		send(alu_instr(op, dr, prev, imm_form, low));
		prev = dr;	// each one reads the result before it
	end
	idle(2);
endtask

task automatic shift_ops;
	logic [1:0] kind;
	send(alu_instr(4'h1, 3'd7, 3'd0, 1'b1, {1'b1, 4'($urandom)}));
	send(alu_instr(4'h1, 3'd6, 3'd0, 1'b1, {1'b0, 4'($urandom_range(15, 1))}));
	for (int i = 0; i < 12; i++) begin
		kind = (i % 3 == 0) ? 2'b00 : ((i % 3 == 1) ? 2'b01 : 2'b11);
		send(shift_instr(3'd5, (i % 2 == 1) ? 3'd7 : 3'd6, kind, 4'($urandom)));
	end
	idle(2);
endtask

task automatic lea_ops;
	for (int i = 0; i < 4; i++) begin
		next_pc = 16'($urandom);
		send(lea_instr(any_dest(), 9'($urandom)));
	end
	idle(2);
endtask

task automatic no_effect_ops;
	logic [3:0] ops [3];
	lc3b_word ins;
	ops = '{4'h7, 4'h0, 4'hf};	// str, br, trap
	for (int i = 0; i < 3; i++) begin
		ins = {ops[i], 12'($urandom)};
		send(ins);
		send(alu_instr(4'h1, ins[11:9], ins[11:9], 1'b1, 5'd0));
	end
	idle(2);
endtask

task automatic stall_sequence;
	lc3b_reg prev;
	lc3b_word ins;
	int hold;
	prev = 3'd5;
	for (int i = 0; i < 10; i++) begin
		case (i % 3)
		0: ins = alu_instr(4'h1, 3'd3, prev, 1'b1, 5'($urandom));
		1: ins = alu_instr(4'h5, 3'd4, prev, 1'b0, {2'b00, prev});
		default: ins = shift_instr(3'd5, prev, 2'($urandom), 4'($urandom));
		endcase
		hold = $urandom_range(2);
		repeat (hold) begin
			issue(ins, next_pc, 1'b1, 1'b1);	// held steady while stalled
		end
		send(ins);
		prev = ins[11:9];
	end
	issue(16'h0000, next_pc, 1'b0, 1'b1);
	idle(3);
endtask

initial begin
	instr = '0;
	pc = '0;
	instr_valid = 1'b0;
	stall = 1'b0;
	model_cc = 3'b010;
	committed_cc = 3'b010;
	edge_cnt = 0;
	stall_cnt = 0;
	next_pc = 16'h3000;
	for (int i = 0; i < 8; i++) begin
		model_regs[i] = '0;
	end
	void'($urandom(32'hd763_e933));
	wait (arst_n);
	@(posedge clk);
	reset_state();
	add_and_ops();
	shift_ops();
	lea_ops();
	no_effect_ops();
	stall_sequence();
	if (pending.size() == 0) begin
		$display("test passed");
		$finish;
	end else begin
		$display("%0d instructions were sent but never retired", pending.size());
		$display("test failed");
		$fatal(1, "instructions lost in the pipeline");
	end
end

endmodule

`default_nettype wire
